//--- exe_stage.f
source/exe_pkg.sv
source/exe_operand_select.sv
source/exe_alu.sv
source/exe_branch_unit.sv
source/exe_muldiv.sv
source/exe_stage.sv
dv/exe_stage_checker.sv
dv/exe_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the exe_stage testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f exe_stage.f \
    --top-module exe_stage_tb -o exe_stage_sim &&
./obj_dir/exe_stage_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" ||
exit 1

//--- dv/exe_stage_tb.sv
`timescale 1ns/1ps

module exe_stage_tb import exe_pkg::*; ();

    logic                       clk;
    logic                       rst_n;
    logic                       left_valid;
    logic                       left_ready;
    logic [data_width-1:0]      pc;
    logic [data_width-1:0]      imm;
    logic [data_width-1:0]      reg1;
    logic [data_width-1:0]      reg2;
    logic [reg_index_width-1:0] reg_index1;
    logic [reg_index_width-1:0] reg_index2;
    logic [reg_index_width-1:0] wreg_index;
    logic                       wreg_en;
    src_sel_t                   src1_sel;
    src_sel_t                   src2_sel;
    alu_op_t                    alu_op;
    branch_op_t                 branch_op;
    muldiv_op_t                 muldiv_op;
    logic                       is_sign;
    logic                       mem_bypass_en;
    logic [reg_index_width-1:0] mem_bypass_index;
    logic [data_width-1:0]      mem_bypass_data;
    logic                       right_valid;
    logic                       right_ready;
    logic [data_width-1:0]      ex_result;
    logic [reg_index_width-1:0] ex_wreg_index;
    logic                       ex_wreg_en;
    logic [data_width-1:0]      ex_pc;
    logic                       branch_taken;
    logic [data_width-1:0]      branch_target;
    logic                       flush_in;

    integer seed;
    integer ready_seed;
    int     errors;
    int     cycle = 0;
    // 0 ready high, 1 random, 2 ready low
    int     ready_mode;
    string  test_name;

    // one entry per accepted instruction, popped on each transfer
    logic [data_width-1:0]      exp_data[$];
    logic [reg_index_width-1:0] exp_index[$];
    logic                       exp_en[$];
    logic [data_width-1:0]      exp_pc[$];
    int                         exp_cycle[$];

    exe_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // downstream ready pattern
    initial begin
        right_ready = 1'b1;
        ready_seed  = 32'h56ed8cfc;
        forever begin
            @(posedge clk);
            #1;
            if (ready_mode == 1)
                right_ready = 1'($random(ready_seed));
            else
                right_ready = (ready_mode == 0);
        end
    end

    task automatic compare_data(input string what, input logic [data_width-1:0] expected,
                                input logic [data_width-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_index(input string what, input logic [reg_index_width-1:0] expected,
                                 input logic [reg_index_width-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s %s expected %b actual %b", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // write data and branch outcome straight from the instruction rules
    function automatic logic [data_width-1:0] expected_result(output logic taken);
        logic [data_width-1:0] f1;
        logic [data_width-1:0] f2;
        logic [data_width-1:0] s1;
        logic [data_width-1:0] s2;
        logic [63:0]           prod;
        logic                  ovf;
        logic [data_width-1:0] res;
        // x0 never takes the bypass
        f1 = reg1;
        f2 = reg2;
        if (mem_bypass_en && mem_bypass_index == reg_index1 && reg_index1 != '0)
            f1 = mem_bypass_data;
        if (mem_bypass_en && mem_bypass_index == reg_index2 && reg_index2 != '0)
            f2 = mem_bypass_data;
        s1 = (src1_sel == sel_imm) ? imm : (src1_sel == sel_pc) ? pc : f1;
        s2 = (src2_sel == sel_imm) ? imm : (src2_sel == sel_pc) ? pc : f2;
        case (alu_op)
            add:     res = s1 + s2;
            sub:     res = s1 - s2;
            slt:     res = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
            sltu:    res = (s1 < s2) ? 32'd1 : 32'd0;
            and_op:  res = s1 & s2;
            or_op:   res = s1 | s2;
            xor_op:  res = s1 ^ s2;
            nor_op:  res = ~(s1 | s2);
            sll:     res = s1 << s2[4:0];
            srl:     res = s1 >> s2[4:0];
            sra:     res = $signed(s1) >>> s2[4:0];
            lui_op:  res = s2;
            default: res = '0;
        endcase
        // most negative over minus one
        ovf = is_sign && s1 == 32'h8000_0000 && s2 == '1;
        case (muldiv_op)
            mul_lo: begin
                prod = {32'b0, s1} * {32'b0, s2};
                res  = prod[31:0];
            end
            mul_hi: begin
                if (is_sign)
                    prod = $signed({{32{s1[31]}}, s1}) * $signed({{32{s2[31]}}, s2});
                else
                    prod = {32'b0, s1} * {32'b0, s2};
                res = prod[63:32];
            end
            div: begin
                if (s2 == '0)
                    res = '1;
                else if (ovf)
                    res = s1;
                else if (is_sign)
                    res = $signed(s1) / $signed(s2);
                else
                    res = s1 / s2;
            end
            mod: begin
                if (s2 == '0)
                    res = s1;
                else if (ovf)
                    res = '0;
                else if (is_sign)
                    res = $signed(s1) % $signed(s2);
                else
                    res = s1 % s2;
            end
            default: ;
        endcase
        case (branch_op)
            jump:    taken = 1'b1;
            beq:     taken = f1 == f2;
            bne:     taken = f1 != f2;
            blt:     taken = $signed(f1) < $signed(f2);
            bge:     taken = $signed(f1) >= $signed(f2);
            bltu:    taken = f1 < f2;
            bgeu:    taken = f1 >= f2;
            default: taken = 1'b0;
        endcase
        // link address
        if (branch_op == jump)
            res = pc + 32'd4;
        return res;
    endfunction

    // small index range so x0 and bypass hits come up often
    task automatic random_fields();
        pc               = $random(seed);
        pc[1:0]          = 2'b00;
        imm              = $random(seed);
        reg1             = $random(seed);
        reg2             = $random(seed);
        reg_index1       = 5'({$random(seed)} % 4);
        reg_index2       = 5'({$random(seed)} % 4);
        wreg_index       = 5'($random(seed));
        wreg_en          = 1'($random(seed));
        src1_sel         = src_sel_t'(2'({$random(seed)} % 3));
        src2_sel         = src_sel_t'(2'({$random(seed)} % 3));
        alu_op           = alu_op_t'(4'({$random(seed)} % 12));
        branch_op        = br_none;
        muldiv_op        = md_none;
        is_sign          = 1'($random(seed));
        mem_bypass_en    = 1'($random(seed));
        mem_bypass_index = 1'($random(seed)) ? reg_index1 : 5'({$random(seed)} % 4);
        mem_bypass_data  = $random(seed);
    endtask

    // present one instruction, queue its expectation at acceptance
    task automatic issue(input logic is_md);
        int                    waited;
        logic                  taken;
        logic [data_width-1:0] exp;
        waited     = 0;
        left_valid = 1'b1;
        @(negedge clk);
        while (left_ready !== 1'b1 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (left_ready !== 1'b1) begin
            $display("timeout in %s: instruction at pc %h never accepted", test_name, pc);
            errors++;
        end else begin
            exp = expected_result(taken);
            compare_flag("branch_taken", taken, branch_taken);
            if (taken)
                compare_data("branch_target", pc + imm, branch_target);
            // upstream held for the whole iteration
            if (is_md)
                compare_flag("muldiv_wait", 1'b1, waited >= muldiv_steps);
            exp_data.push_back(exp);
            exp_index.push_back(wreg_index);
            exp_en.push_back(wreg_en);
            exp_pc.push_back(pc);
            exp_cycle.push_back(ready_mode == 0 ? cycle : -1);
        end
        @(posedge clk);
        #1;
        left_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            $display("timeout in %s: %0d results never left the stage",
                     test_name, exp_data.size());
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    // change mode away from the edge the ready process drives on
    task automatic set_ready_mode(input int mode);
        @(negedge clk);
        ready_mode = mode;
        @(posedge clk);
        #1;
    endtask

    task automatic clear_expected();
        exp_data.delete();
        exp_index.delete();
        exp_en.delete();
        exp_pc.delete();
        exp_cycle.delete();
    endtask

    // pops one expectation per downstream transfer
    initial begin
        int acc;
        forever begin
            @(negedge clk);
            if (rst_n && right_valid && right_ready) begin
                if (exp_data.size() == 0) begin
                    $display("transfer in %s with no instruction outstanding", test_name);
                    errors++;
                end else begin
                    compare_data("ex_result", exp_data.pop_front(), ex_result);
                    compare_index("ex_wreg_index", exp_index.pop_front(), ex_wreg_index);
                    compare_flag("ex_wreg_en", exp_en.pop_front(), ex_wreg_en);
                    compare_data("ex_pc", exp_pc.pop_front(), ex_pc);
                    acc = exp_cycle.pop_front();
                    // one cycle from acceptance with ready held high
                    if (acc >= 0 && ready_mode == 0)
                        compare_flag("latency", 1'b1, cycle == acc + 1);
                end
            end
        end
    end

    initial begin
        seed       = 32'h56ed8cfc;
        errors     = 0;
        ready_mode = 0;
        test_name  = "reset";
        rst_n      = 1'b0;
        flush_in   = 1'b0;
        left_valid = 1'b0;
        random_fields();
        // a jump without left_valid must not redirect
        branch_op  = jump;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_flag("right_valid", 1'b0, right_valid);
        compare_flag("branch_taken", 1'b0, branch_taken);
        @(posedge clk);
        #1;

        // random alu, forwarding mixed in
        test_name = "alu_random";
        repeat (60) begin
            random_fields();
            issue(1'b0);
        end

        // x0, a hit and a miss
        test_name = "forward";
        random_fields();
        alu_op           = add;
        src1_sel         = sel_reg;
        reg_index1       = '0;
        mem_bypass_en    = 1'b1;
        mem_bypass_index = '0;
        issue(1'b0);
        random_fields();
        alu_op           = add;
        src1_sel         = sel_reg;
        src2_sel         = sel_reg;
        reg_index1       = 5'd7;
        reg_index2       = 5'd7;
        mem_bypass_en    = 1'b1;
        mem_bypass_index = 5'd7;
        issue(1'b0);
        random_fields();
        alu_op           = add;
        src1_sel         = sel_reg;
        reg_index1       = 5'd3;
        mem_bypass_en    = 1'b1;
        mem_bypass_index = 5'd9;
        issue(1'b0);

        // every kind, target is pc plus imm through the alu
        test_name = "branch";
        for (int b = 0; b < 8; b++) begin
            repeat (6) begin
                random_fields();
                if (1'($random(seed)))
                    reg2 = reg1;
                src1_sel  = sel_pc;
                src2_sel  = sel_imm;
                alu_op    = add;
                branch_op = branch_op_t'(3'(b));
                issue(1'b0);
            end
        end

        // random, divide by zero, signed overflow, small operands
        test_name = "muldiv";
        for (int m = 1; m < 5; m++) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 0; k < 4; k++) begin
                    random_fields();
                    src1_sel      = sel_reg;
                    src2_sel      = sel_reg;
                    mem_bypass_en = 1'b0;
                    muldiv_op     = muldiv_op_t'(3'(m));
                    is_sign       = 1'(s);
                    if (k == 1)
                        reg2 = '0;
                    if (k == 2) begin
                        reg1 = 32'h8000_0000;
                        reg2 = '1;
                    end
                    if (k == 3)
                        reg2 = 32'($signed(reg2) >>> 24);
                    issue(1'b1);
                end
            end
        end
        drain();

        test_name = "backpressure";
        set_ready_mode(1);
        repeat (40) begin
            random_fields();
            if ({$random(seed)} % 4 == 0)
                muldiv_op = muldiv_op_t'(3'(1 + {$random(seed)} % 4));
            issue(muldiv_op != md_none);
        end
        drain();

        // flush a result stuck on a stalled output
        test_name = "flush_held";
        set_ready_mode(2);
        random_fields();
        issue(1'b0);
        flush_in = 1'b1;
        @(negedge clk);
        clear_expected();
        @(posedge clk);
        #1;
        flush_in = 1'b0;
        @(negedge clk);
        compare_flag("right_valid", 1'b0, right_valid);
        set_ready_mode(0);
        random_fields();
        issue(1'b0);
        drain();

        // abort a divide midway, then run alu and muldiv again
        test_name = "flush_muldiv";
        random_fields();
        src1_sel   = sel_reg;
        src2_sel   = sel_reg;
        muldiv_op  = div;
        left_valid = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        flush_in   = 1'b1;
        left_valid = 1'b0;
        @(posedge clk);
        #1;
        flush_in = 1'b0;
        @(negedge clk);
        compare_flag("right_valid", 1'b0, right_valid);
        compare_flag("md_busy", 1'b0, uut.md_busy);
        @(posedge clk);
        #1;
        random_fields();
        issue(1'b0);
        random_fields();
        muldiv_op = mul_lo;
        issue(1'b1);
        drain();

        // nothing more may come out
        repeat (5) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- dv/exe_stage_checker.sv
`timescale 1ns/1ps

module exe_stage_checker import exe_pkg::*; (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       left_valid,
    input logic                       left_ready,
    input logic                       right_valid,
    input logic                       right_ready,
    input logic [data_width-1:0]      ex_result,
    input logic [reg_index_width-1:0] ex_wreg_index,
    input logic                       ex_wreg_en,
    input logic [data_width-1:0]      ex_pc,
    input logic                       branch_taken,
    input logic                       flush_in,
    input logic                       md_busy
);

    // output register empty once reset has been seen
    assert property (@(posedge clk) !rst_n |=> !right_valid)
        else $error("right_valid high after reset");

    // held output under back-pressure, flush excepted
    assert property (@(posedge clk) disable iff (!rst_n)
        right_valid && !right_ready && !flush_in |=>
        right_valid && $stable(ex_result) && $stable(ex_wreg_index)
        && $stable(ex_wreg_en) && $stable(ex_pc))
        else $error("output changed while held under back-pressure");

    // redirect only for an accepted instruction, which lands in the output register
    assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken && !flush_in |=> right_valid && $past(left_valid && left_ready))
        else $error("branch_taken without an accepted instruction");

    // iterative unit blocks the upstream handshake
    assert property (@(posedge clk) disable iff (!rst_n)
        md_busy |-> !left_ready)
        else $error("left_ready high while the multiply/divide unit is busy");

endmodule

bind exe_stage exe_stage_checker u_checker (.*);

//--- source/exe_stage.sv
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    // decode side
    input  logic                       left_valid,
    output logic                       left_ready,
    input  logic [data_width-1:0]      pc,
    input  logic [data_width-1:0]      imm,
    input  logic [data_width-1:0]      reg1,
    input  logic [data_width-1:0]      reg2,
    input  logic [reg_index_width-1:0] reg_index1,
    input  logic [reg_index_width-1:0] reg_index2,
    input  logic [reg_index_width-1:0] wreg_index,
    input  logic                       wreg_en,
    input  src_sel_t                   src1_sel,
    input  src_sel_t                   src2_sel,
    input  alu_op_t                    alu_op,
    input  branch_op_t                 branch_op,
    input  muldiv_op_t                 muldiv_op,
    input  logic                       is_sign,
    // memory stage forwarding
    input  logic                       mem_bypass_en,
    input  logic [reg_index_width-1:0] mem_bypass_index,
    input  logic [data_width-1:0]      mem_bypass_data,
    // memory stage side
    output logic                       right_valid,
    input  logic                       right_ready,
    output logic [data_width-1:0]      ex_result,
    output logic [reg_index_width-1:0] ex_wreg_index,
    output logic                       ex_wreg_en,
    output logic [data_width-1:0]      ex_pc,
    // fetch redirect
    output logic                       branch_taken,
    output logic [data_width-1:0]      branch_target,
    input  logic                       flush_in
);

    logic [data_width-1:0] fwd_reg1;
    logic [data_width-1:0] fwd_reg2;
    logic [data_width-1:0] src1;
    logic [data_width-1:0] src2;
    logic [data_width-1:0] alu_result;
    logic [data_width-1:0] md_result;
    logic [data_width-1:0] write_data;
    logic                  md_busy;
    logic                  md_done;
    logic                  md_start;
    logic                  is_muldiv;
    logic                  out_free;
    logic                  fire;

    exe_operand_select u_operand_select (
        .reg1             (reg1),
        .reg2             (reg2),
        .reg_index1       (reg_index1),
        .reg_index2       (reg_index2),
        .pc               (pc),
        .imm              (imm),
        .src1_sel         (src1_sel),
        .src2_sel         (src2_sel),
        .mem_bypass_en    (mem_bypass_en),
        .mem_bypass_index (mem_bypass_index),
        .mem_bypass_data  (mem_bypass_data),
        .fwd_reg1         (fwd_reg1),
        .fwd_reg2         (fwd_reg2),
        .src1             (src1),
        .src2             (src2)
    );

    exe_alu u_alu (
        .alu_op (alu_op),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    // target comes from the alu sum of pc and imm
    exe_branch_unit u_branch_unit (
        .fire          (fire),
        .branch_op     (branch_op),
        .fwd_reg1      (fwd_reg1),
        .fwd_reg2      (fwd_reg2),
        .target        (alu_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    exe_muldiv u_muldiv (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush_in (flush_in),
        .start    (md_start),
        .hold     (!fire),
        .op       (muldiv_op),
        .is_sign  (is_sign),
        .src1     (src1),
        .src2     (src2),
        .busy     (md_busy),
        .done     (md_done),
        .result   (md_result)
    );

    assign is_muldiv = muldiv_op != md_none;

    // output register empty or draining this cycle
    assign out_free = right_ready || !right_valid;

    // muldiv holds the instruction until its result is ready
    assign left_ready = out_free && (!is_muldiv || md_done);
    assign fire       = left_valid && left_ready;

    // kick off once per instruction
    assign md_start = left_valid && is_muldiv && !md_busy && !md_done;

    // link address, muldiv or alu
    always_comb begin
        if (branch_op == jump)
            write_data = pc + data_width'(4);
        else if (is_muldiv)
            write_data = md_result;
        else
            write_data = alu_result;
    end

    // flush wins over a same-cycle acceptance
    always_ff @(posedge clk) begin
        if (!rst_n || flush_in) begin
            right_valid <= 1'b0;
        end else if (fire) begin
            right_valid <= 1'b1;
        end else if (right_ready) begin
            right_valid <= 1'b0;
        end
    end

    // payload only moves on acceptance
    always_ff @(posedge clk) begin
        if (fire) begin
            ex_result     <= write_data;
            ex_wreg_index <= wreg_index;
            ex_wreg_en    <= wreg_en;
            ex_pc         <= pc;
        end
    end

endmodule

//--- source/exe_muldiv.sv
`timescale 1ns/1ps

module exe_muldiv import exe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_in,
    input  logic                  start,
    input  logic                  hold,
    input  muldiv_op_t            op,
    input  logic                  is_sign,
    input  logic [data_width-1:0] src1,
    input  logic [data_width-1:0] src2,
    output logic                  busy,
    output logic                  done,
    output logic [data_width-1:0] result
);

    logic [$clog2(muldiv_steps)-1:0] count;
    muldiv_op_t                      op_q;
    logic                            is_div;
    logic                            neg_main;
    logic                            neg_rem;
    logic                            div_zero;
    logic [data_width-1:0]           operand;
    logic [2*data_width-1:0]         acc;
    logic [data_width-1:0]           mag1;
    logic [data_width-1:0]           mag2;
    logic [data_width:0]             add_sum;
    logic [data_width:0]             partial;
    logic [data_width:0]             trial;
    logic [2*data_width-1:0]         product;
    logic [data_width-1:0]           quotient;
    logic [data_width-1:0]           remainder;

    // signed operands run as magnitudes
    assign mag1 = (is_sign && src1[data_width-1]) ? -src1 : src1;
    assign mag2 = (is_sign && src2[data_width-1]) ? -src2 : src2;

    assign is_div = (op_q == div) || (op_q == mod);

    // shift-add, multiplier bits leave from the bottom
    assign add_sum = {1'b0, acc[2*data_width-1:data_width]}
                   + (acc[0] ? {1'b0, operand} : '0);

    // remainder shifted left with the next dividend bit
    assign partial = acc[2*data_width-1:data_width-1];
    assign trial   = partial - {1'b0, operand};

    // busy for muldiv_steps cycles, done held until taken
    always_ff @(posedge clk) begin
        if (!rst_n || flush_in) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (int'(count) == muldiv_steps - 1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (done && !hold) begin
            done <= 1'b0;
        end
    end

    // operands latched at start, one step per busy cycle
    always_ff @(posedge clk) begin
        if (start) begin
            op_q     <= op;
            neg_main <= is_sign && (src1[data_width-1] ^ src2[data_width-1]);
            neg_rem  <= is_sign && src1[data_width-1];
            div_zero <= src2 == '0;
            operand  <= mag2;
            acc      <= {{data_width{1'b0}}, mag1};
        end else if (busy) begin
            // restoring divide, quotient bits enter from the bottom
            if (is_div)
                acc <= trial[data_width]
                     ? {partial[data_width-1:0], acc[data_width-2:0], 1'b0}
                     : {trial[data_width-1:0], acc[data_width-2:0], 1'b1};
            else
                acc <= {add_sum, acc[data_width-1:1]};
        end
    end

    // sign correction on the whole product
    assign product   = neg_main ? -acc : acc;
    // divide by zero gives all ones
    assign quotient  = div_zero ? '1
                     : neg_main ? -acc[data_width-1:0] : acc[data_width-1:0];
    // remainder follows the dividend sign
    assign remainder = neg_rem ? -acc[2*data_width-1:data_width]
                               : acc[2*data_width-1:data_width];

    always_comb begin
        case (op_q)
            mul_lo:  result = product[data_width-1:0];
            mul_hi:  result = product[2*data_width-1:data_width];
            div:     result = quotient;
            mod:     result = remainder;
            default: result = '0;
        endcase
    end

endmodule

//--- source/exe_branch_unit.sv
`timescale 1ns/1ps

module exe_branch_unit import exe_pkg::*; (
    input  logic                  fire,
    input  branch_op_t            branch_op,
    input  logic [data_width-1:0] fwd_reg1,
    input  logic [data_width-1:0] fwd_reg2,
    input  logic [data_width-1:0] target,
    output logic                  branch_taken,
    output logic [data_width-1:0] branch_target
);

    logic equal;
    logic less_signed;
    logic less_unsigned;
    logic cond;

    // compare on forwarded registers, not on the selected sources
    assign equal         = fwd_reg1 == fwd_reg2;
    assign less_signed   = $signed(fwd_reg1) < $signed(fwd_reg2);
    assign less_unsigned = fwd_reg1 < fwd_reg2;

    always_comb begin
        case (branch_op)
            jump:    cond = 1'b1;
            beq:     cond = equal;
            bne:     cond = !equal;
            blt:     cond = less_signed;
            bge:     cond = !less_signed;
            bltu:    cond = less_unsigned;
            bgeu:    cond = !less_unsigned;
            default: cond = 1'b0;
        endcase
    end

    // only in the acceptance cycle
    assign branch_taken  = fire && cond;
    // pc plus imm from the alu adder
    assign branch_target = target;

endmodule

//--- source/exe_alu.sv
`timescale 1ns/1ps

module exe_alu import exe_pkg::*; (
    input  alu_op_t               alu_op,
    input  logic [data_width-1:0] src1,
    input  logic [data_width-1:0] src2,
    output logic [data_width-1:0] result
);

    // shift amount from the low bits of src2
    logic [$clog2(data_width)-1:0] shamt;
    logic                          lt_signed;
    logic                          lt_unsigned;

    assign shamt       = src2[$clog2(data_width)-1:0];
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            add: begin
                result = src1 + src2;
            end
            sub: begin
                result = src1 - src2;
            end
            // compares give 0 or 1
            slt: begin
                result = data_width'(lt_signed);
            end
            sltu: begin
                result = data_width'(lt_unsigned);
            end
            and_op: begin
                result = src1 & src2;
            end
            or_op: begin
                result = src1 | src2;
            end
            xor_op: begin
                result = src1 ^ src2;
            end
            nor_op: begin
                result = ~(src1 | src2);
            end
            sll: begin
                result = src1 << shamt;
            end
            srl: begin
                result = src1 >> shamt;
            end
            // arithmetic, sign bit fills from the left
            sra: begin
                result = $signed(src1) >>> shamt;
            end
            // upper immediate already built by decode
            lui_op: begin
                result = src2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- source/exe_operand_select.sv
`timescale 1ns/1ps

module exe_operand_select import exe_pkg::*; (
    input  logic [data_width-1:0]      reg1,
    input  logic [data_width-1:0]      reg2,
    input  logic [reg_index_width-1:0] reg_index1,
    input  logic [reg_index_width-1:0] reg_index2,
    input  logic [data_width-1:0]      pc,
    input  logic [data_width-1:0]      imm,
    input  src_sel_t                   src1_sel,
    input  src_sel_t                   src2_sel,
    input  logic                       mem_bypass_en,
    input  logic [reg_index_width-1:0] mem_bypass_index,
    input  logic [data_width-1:0]      mem_bypass_data,
    output logic [data_width-1:0]      fwd_reg1,
    output logic [data_width-1:0]      fwd_reg2,
    output logic [data_width-1:0]      src1,
    output logic [data_width-1:0]      src2
);

    // x0 is hardwired, never forwarded
    function automatic logic [data_width-1:0] forward(
        input logic [data_width-1:0]      value,
        input logic [reg_index_width-1:0] index
    );
        if (mem_bypass_en && (mem_bypass_index == index) && (index != '0))
            return mem_bypass_data;
        return value;
    endfunction

    // reg, imm or pc into the alu and muldiv
    function automatic logic [data_width-1:0] select_src(
        input src_sel_t              sel,
        input logic [data_width-1:0] value
    );
        case (sel)
            sel_imm: return imm;
            sel_pc:  return pc;
            default: return value;
        endcase
    endfunction

    always_comb begin
        fwd_reg1 = forward(reg1, reg_index1);
        fwd_reg2 = forward(reg2, reg_index2);
        // sources see the forwarded values
        src1     = select_src(src1_sel, fwd_reg1);
        src2     = select_src(src2_sel, fwd_reg2);
    end

endmodule

//--- source/exe_pkg.sv
package exe_pkg;

    // integer data path and register file sizes
    localparam int data_width      = 32;
    localparam int reg_index_width = 5;

    // one iteration per operand bit
    localparam int muldiv_steps    = 32;

    // single-cycle alu operations
    // lui_op passes the second source straight through
    typedef enum logic [3:0] {
        add,
        sub,
        slt,
        sltu,
        and_op,
        or_op,
        xor_op,
        nor_op,
        sll,
        srl,
        sra,
        lui_op
    } alu_op_t;

    // branch kinds, jump is unconditional
    typedef enum logic [2:0] {
        br_none,
        jump,
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu
    } branch_op_t;

    // iterative unit operations
    typedef enum logic [2:0] {
        md_none,
        mul_lo,
        mul_hi,
        div,
        mod
    } muldiv_op_t;

    // operand source
    typedef enum logic [1:0] {
        sel_reg,
        sel_imm,
        sel_pc
    } src_sel_t;

endpackage
